//--- include/fmul_params.svh
`ifndef FMUL_PARAMS_SVH
`define FMUL_PARAMS_SVH

// total latency from an input transfer to the matching output, in cycles
`define FMUL_DEPTH 5

// smallest legal latency
// two stage registers plus the output register
`define FMUL_MIN_DEPTH 3

// canonical quiet NaN for invalid operations such as zero times infinity
`define FMUL_QNAN 32'hffc0_0000

`endif

//--- logic/fp32_pkg.sv
`default_nettype none

// Field types of the IEEE-754 binary32 format.
// A word is laid out as {sign, exp_t, mant_t} from bit 31 down to bit 0.
package fp32_pkg;

    typedef logic [31:0] fp32_t;        // whole binary32 word

    typedef logic [7:0] exp_t;          // biased exponent field

    typedef logic [22:0] mant_t;        // stored fraction without the hidden bit

    // Virtual exponent. This is the biased exponent the operand would have
    // once normalized. A normal keeps its field value and a subnormal gets
    // minus the leading zero count of its fraction, so the value can be
    // negative. Ten signed bits hold the sum of two operands less the bias.
    typedef logic signed [9:0] vexp_t;

endpackage

`default_nettype wire

//--- logic/fmul_pkg.sv
`default_nettype none

// Types of the payloads that travel between the multiplier stages.
package fmul_pkg;

    typedef logic [5:0] shift_t;        // right shift into the rounding window

    typedef logic [47:0] prod_t;        // raw product of two 24-bit significands

    // Aligned significand seen by the rounder. The leading one sits in
    // bit 25 or bit 24. Below the kept fraction come the guard bit and a
    // low round bit, and whatever falls past bit 0 goes into sticky.
    typedef logic [25:0] rnd_t;

endpackage

`default_nettype wire

//--- logic/fmul_classify.sv
`timescale 1ns/1ps
`default_nettype none

`include "fmul_params.svh"

module fmul_classify (
    input  fp32_pkg::fp32_t lhs,
    input  fp32_pkg::fp32_t rhs,
    output fp32_pkg::vexp_t lhs_vexp,
    output fp32_pkg::vexp_t rhs_vexp,
    output fp32_pkg::vexp_t prod_vexp,
    output logic            res_sign,
    output logic            subnormal,
    output logic            res_zero,
    output logic            res_inf,
    output logic            res_nan,
    output fp32_pkg::fp32_t nan_val
);

    fp32_pkg::exp_t  lhs_exp;
    fp32_pkg::exp_t  rhs_exp;
    fp32_pkg::mant_t lhs_mant;
    fp32_pkg::mant_t rhs_mant;
    logic            lhs_is_zero;
    logic            rhs_is_zero;
    logic            lhs_is_inf;
    logic            rhs_is_inf;
    logic            lhs_is_nan;
    logic            rhs_is_nan;

    // leading zeros of a fraction, 23 when it is all zero
    function automatic fp32_pkg::vexp_t count_lz(input fp32_pkg::mant_t m);
        fp32_pkg::vexp_t n;
        logic            found;
        n = 10'sd23;
        found = 1'b0;
        for (int i = 22; i >= 0; i--) begin
            if (m[i] && !found) begin
                n = fp32_pkg::vexp_t'(22 - i);
                found = 1'b1;
            end
        end
        return n;
    endfunction

    assign lhs_exp  = lhs[30:23];
    assign rhs_exp  = rhs[30:23];
    assign lhs_mant = lhs[22:0];
    assign rhs_mant = rhs[22:0];

    assign lhs_is_zero = (lhs_exp == 8'h00) && (lhs_mant == '0);
    assign rhs_is_zero = (rhs_exp == 8'h00) && (rhs_mant == '0);
    assign lhs_is_inf  = (lhs_exp == 8'hff) && (lhs_mant == '0);
    assign rhs_is_inf  = (rhs_exp == 8'hff) && (rhs_mant == '0);
    assign lhs_is_nan  = (lhs_exp == 8'hff) && (lhs_mant != '0);
    assign rhs_is_nan  = (rhs_exp == 8'hff) && (rhs_mant != '0);

    // subnormals are placed below exponent 1 by their leading zero count
    assign lhs_vexp = (lhs_exp == 8'h00) ? -count_lz(lhs_mant)
                                         : fp32_pkg::vexp_t'({2'b00, lhs_exp});
    assign rhs_vexp = (rhs_exp == 8'h00) ? -count_lz(rhs_mant)
                                         : fp32_pkg::vexp_t'({2'b00, rhs_exp});

    assign prod_vexp = lhs_vexp + rhs_vexp - 10'sd127;   // biased, ignores the 2x carry
    assign res_sign  = lhs[31] ^ rhs[31];

    assign subnormal = prod_vexp <= 10'sd0;
    assign res_zero  = (prod_vexp <= -10'sd25) || lhs_is_zero || rhs_is_zero;
    assign res_inf   = (prod_vexp >= 10'sd255) || lhs_is_inf || rhs_is_inf;

    assign res_nan = lhs_is_nan || rhs_is_nan
                  || (lhs_is_zero && rhs_is_inf)
                  || (lhs_is_inf && rhs_is_zero);

    // an input NaN is quieted and passed on, lhs first
    always_comb begin
        if (lhs_is_nan) begin
            nan_val = {lhs[31:23], 1'b1, lhs[21:0]};
        end else if (rhs_is_nan) begin
            nan_val = {rhs[31:23], 1'b1, rhs[21:0]};
        end else begin
            nan_val = `FMUL_QNAN;           // invalid operation
        end
    end

endmodule

`default_nettype wire

//--- logic/fmul_mant_mult.sv
`timescale 1ns/1ps
`default_nettype none

module fmul_mant_mult (
    input  logic             clk,
    input  logic             en,
    input  fp32_pkg::fp32_t  lhs,
    input  fp32_pkg::fp32_t  rhs,
    input  fp32_pkg::vexp_t  lhs_vexp,
    input  fp32_pkg::vexp_t  rhs_vexp,
    input  fp32_pkg::vexp_t  prod_vexp,
    input  logic             res_sign,
    input  logic             subnormal,
    input  logic             res_zero,
    input  logic             res_inf,
    input  logic             res_nan,
    input  fp32_pkg::fp32_t  nan_val,
    output fmul_pkg::prod_t  prod,
    output fmul_pkg::shift_t shift,
    output fp32_pkg::vexp_t  prod_vexp_q,
    output logic             res_sign_q,
    output logic             subnormal_q,
    output logic             res_zero_q,
    output logic             res_inf_q,
    output logic             res_nan_q,
    output fp32_pkg::fp32_t  nan_val_q
);

    fp32_pkg::exp_t  lhs_exp_q;
    fp32_pkg::exp_t  rhs_exp_q;
    fp32_pkg::mant_t lhs_mant_q;
    fp32_pkg::mant_t rhs_mant_q;
    fp32_pkg::vexp_t lhs_vexp_q;
    fp32_pkg::vexp_t rhs_vexp_q;
    logic            lhs_sub;
    logic            rhs_sub;
    logic            gen_sub;
    logic            stay_sub;
    logic            escape_sub;
    fp32_pkg::vexp_t other_exp;
    fp32_pkg::vexp_t shift_wide;
    logic [23:0]     lhs_sig;
    logic [23:0]     rhs_sig;

    always_ff @(posedge clk) begin
        if (en) begin
            lhs_exp_q   <= lhs[30:23];
            rhs_exp_q   <= rhs[30:23];
            lhs_mant_q  <= lhs[22:0];
            rhs_mant_q  <= rhs[22:0];
            lhs_vexp_q  <= lhs_vexp;
            rhs_vexp_q  <= rhs_vexp;
            prod_vexp_q <= prod_vexp;
            res_sign_q  <= res_sign;
            subnormal_q <= subnormal;
            res_zero_q  <= res_zero;
            res_inf_q   <= res_inf;
            res_nan_q   <= res_nan;
            nan_val_q   <= nan_val;
        end
    end

    assign lhs_sub = lhs_exp_q == 8'h00;
    assign rhs_sub = rhs_exp_q == 8'h00;

    assign gen_sub    = subnormal_q && !lhs_sub && !rhs_sub;    // normal x normal -> subnormal
    assign stay_sub   = subnormal_q && (lhs_sub || rhs_sub);    // subnormal stays subnormal
    assign escape_sub = !subnormal_q && (lhs_sub || rhs_sub);   // subnormal back to normal

    // exponent field of the normal operand when the other one is subnormal
    assign other_exp = lhs_sub ? fp32_pkg::vexp_t'({2'b00, rhs_exp_q})
                               : fp32_pkg::vexp_t'({2'b00, lhs_exp_q});

    // 23 is the plain normal alignment, the other cases move around it
    always_comb begin
        if (gen_sub) begin
            shift_wide = 10'sd23 - prod_vexp_q;
        end else if (stay_sub) begin
            shift_wide = 10'sd149 - other_exp;
        end else if (escape_sub) begin
            shift_wide = 10'sd22 + (lhs_sub ? lhs_vexp_q : rhs_vexp_q);
        end else begin
            shift_wide = 10'sd23;
        end
    end

    assign shift = shift_wide[5:0];         // fits whenever the result is not forced

    assign lhs_sig = {!lhs_sub, lhs_mant_q};    // hidden bit restored
    assign rhs_sig = {!rhs_sub, rhs_mant_q};
    assign prod    = fmul_pkg::prod_t'(lhs_sig) * fmul_pkg::prod_t'(rhs_sig);

endmodule

`default_nettype wire

//--- logic/fmul_round_pack.sv
`timescale 1ns/1ps
`default_nettype none

module fmul_round_pack (
    input  logic             clk,
    input  logic             en,
    input  fmul_pkg::prod_t  prod,
    input  fmul_pkg::shift_t shift,
    input  fp32_pkg::vexp_t  prod_vexp,
    input  logic             res_sign,
    input  logic             subnormal,
    input  logic             res_zero,
    input  logic             res_inf,
    input  logic             res_nan,
    input  fp32_pkg::fp32_t  nan_val,
    output fp32_pkg::fp32_t  packed_res
);

    fmul_pkg::prod_t  prod_q;
    fmul_pkg::shift_t shift_q;
    fp32_pkg::vexp_t  prod_vexp_q;
    logic             res_sign_q;
    logic             subnormal_q;
    logic             res_zero_q;
    logic             res_inf_q;
    logic             res_nan_q;
    fp32_pkg::fp32_t  nan_val_q;

    fmul_pkg::rnd_t   aligned;
    logic [6:0]       keep_sh;
    fmul_pkg::prod_t  lost;
    logic             sticky;
    logic             wide;
    logic             round_up;
    logic             exp_inc;
    fp32_pkg::mant_t  mant_sel;
    fp32_pkg::mant_t  res_mant;
    fp32_pkg::exp_t   res_exp;

    always_ff @(posedge clk) begin
        if (en) begin
            prod_q      <= prod;
            shift_q     <= shift;
            prod_vexp_q <= prod_vexp;
            res_sign_q  <= res_sign;
            subnormal_q <= subnormal;
            res_zero_q  <= res_zero;
            res_inf_q   <= res_inf;
            res_nan_q   <= res_nan;
            nan_val_q   <= nan_val;
        end
    end

    assign aligned = fmul_pkg::rnd_t'({prod_q, 1'b0} >> shift_q);

    // product bits that fell below bit 0 of the aligned value
    assign keep_sh = 7'd49 - {1'b0, shift_q};
    assign lost    = prod_q << keep_sh;
    assign sticky  = |lost;

    // the fraction starts one bit higher for a subnormal or a 2x product
    assign wide = subnormal_q || aligned[25];

    // nearest even
    assign round_up = wide ? aligned[1] & (aligned[2] | aligned[0] | sticky)
                           : aligned[0] & (aligned[1] | sticky);

    assign mant_sel = wide ? aligned[24:2] : aligned[23:1];
    assign res_mant = mant_sel + fp32_pkg::mant_t'(round_up);   // wraps to zero on carry-out

    // carry into the exponent from the 2x product or from rounding
    assign exp_inc = subnormal_q ? (aligned >= 26'h1ff_fffe) : (aligned >= 26'h1ff_ffff);
    assign res_exp = subnormal_q ? fp32_pkg::exp_t'(exp_inc)
                                 : prod_vexp_q[7:0] + fp32_pkg::exp_t'(exp_inc);

    always_comb begin
        if (res_nan_q) begin
            packed_res = nan_val_q;
        end else if (res_zero_q) begin
            packed_res = {res_sign_q, 8'h00, 23'h0};
        end else if (res_inf_q || res_exp == 8'hff) begin
            packed_res = {res_sign_q, 8'hff, 23'h0};    // overflow after rounding too
        end else begin
            packed_res = {res_sign_q, res_exp, res_mant};
        end
    end

endmodule

`default_nettype wire

//--- logic/fmul_pipe.sv
`timescale 1ns/1ps
`default_nettype none

`include "fmul_params.svh"

module fmul_pipe #(
    parameter int depth = `FMUL_DEPTH
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    output logic            in_ready,
    input  fp32_pkg::fp32_t lhs,
    input  fp32_pkg::fp32_t rhs,
    output logic            out_valid,
    input  logic            out_ready,
    output fp32_pkg::fp32_t result
);

    logic [depth-1:0] vld;          // one valid bit per register slot
    logic             advance;

    fp32_pkg::vexp_t  lhs_vexp;
    fp32_pkg::vexp_t  rhs_vexp;
    fp32_pkg::vexp_t  prod_vexp;
    logic             res_sign;
    logic             subnormal;
    logic             res_zero;
    logic             res_inf;
    logic             res_nan;
    fp32_pkg::fp32_t  nan_val;

    fmul_pkg::prod_t  s1_prod;
    fmul_pkg::shift_t s1_shift;
    fp32_pkg::vexp_t  s1_prod_vexp;
    logic             s1_res_sign;
    logic             s1_subnormal;
    logic             s1_res_zero;
    logic             s1_res_inf;
    logic             s1_res_nan;
    fp32_pkg::fp32_t  s1_nan_val;

    fp32_pkg::fp32_t  packed_res;
    fp32_pkg::fp32_t  dly [0:depth-3];  // padding stages plus the output register

    if (depth < `FMUL_MIN_DEPTH) begin : g_depth_check
        $error("fmul_pipe depth must be at least %0d", `FMUL_MIN_DEPTH);
    end

    // the whole pipe moves as one unless a finished result is held back
    assign advance   = !vld[depth-1] || out_ready;
    assign in_ready  = advance;
    assign out_valid = vld[depth-1];
    assign result    = dly[depth-3];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld <= '0;
        end else if (advance) begin
            vld <= {vld[depth-2:0], in_valid};  // bubble when in_valid is low
        end
    end

    fmul_classify u_classify (
        .lhs       (lhs),
        .rhs       (rhs),
        .lhs_vexp  (lhs_vexp),
        .rhs_vexp  (rhs_vexp),
        .prod_vexp (prod_vexp),
        .res_sign  (res_sign),
        .subnormal (subnormal),
        .res_zero  (res_zero),
        .res_inf   (res_inf),
        .res_nan   (res_nan),
        .nan_val   (nan_val)
    );

    fmul_mant_mult u_mant_mult (
        .clk         (clk),
        .en          (advance),
        .lhs         (lhs),
        .rhs         (rhs),
        .lhs_vexp    (lhs_vexp),
        .rhs_vexp    (rhs_vexp),
        .prod_vexp   (prod_vexp),
        .res_sign    (res_sign),
        .subnormal   (subnormal),
        .res_zero    (res_zero),
        .res_inf     (res_inf),
        .res_nan     (res_nan),
        .nan_val     (nan_val),
        .prod        (s1_prod),
        .shift       (s1_shift),
        .prod_vexp_q (s1_prod_vexp),
        .res_sign_q  (s1_res_sign),
        .subnormal_q (s1_subnormal),
        .res_zero_q  (s1_res_zero),
        .res_inf_q   (s1_res_inf),
        .res_nan_q   (s1_res_nan),
        .nan_val_q   (s1_nan_val)
    );

    fmul_round_pack u_round_pack (
        .clk        (clk),
        .en         (advance),
        .prod       (s1_prod),
        .shift      (s1_shift),
        .prod_vexp  (s1_prod_vexp),
        .res_sign   (s1_res_sign),
        .subnormal  (s1_subnormal),
        .res_zero   (s1_res_zero),
        .res_inf    (s1_res_inf),
        .res_nan    (s1_res_nan),
        .nan_val    (s1_nan_val),
        .packed_res (packed_res)
    );

    // last element is the output register
    always_ff @(posedge clk) begin
        if (advance) begin
            dly[0] <= packed_res;
            for (int i = 1; i < depth - 2; i++) begin
                dly[i] <= dly[i-1];
            end
        end
    end

endmodule

`default_nettype wire

//--- tests/fmul_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module fmul_clk_gen #(
    parameter int period_ns    = 40,
    parameter int reset_cycles = 5
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1 rst_n = 1'b1;                    // released just after an edge
    end

endmodule

`default_nettype wire

//--- tests/fmul_assert.sv
`timescale 1ns/1ps
`default_nettype none

module fmul_assert (
    input logic            clk,
    input logic            rst_n,
    input logic            in_ready,
    input logic            out_valid,
    input logic            out_ready,
    input fp32_pkg::fp32_t result
);

    int fail_count = 0;                     // read by the testbench at the end

    // valid bits are cleared by a reset cycle
    a_reset_clears: assert property (@(posedge clk) !rst_n |=> !out_valid)
        else begin
            $error("out_valid high right after a reset cycle");
            fail_count++;
        end

    a_hold_result: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(result))
        else begin
            $error("result or out_valid changed while the output was blocked");
            fail_count++;
        end

    // the input side stalls exactly when a finished result is held back
    a_ready_rule: assert property (@(posedge clk) disable iff (!rst_n)
        in_ready == !(out_valid && !out_ready))
        else begin
            $error("in_ready does not match the output stall state");
            fail_count++;
        end

endmodule

`default_nettype wire

//--- tests/fmul_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fmul_params.svh"

module fmul_tb;

    localparam int depth      = `FMUL_DEPTH;
    localparam int n_random   = 2000;
    localparam int n_stall    = 400;
    localparam int n_directed = 40;         // upper bound on directed operations
    localparam int total_ops  = n_random + n_stall + n_directed + 1;

    logic            clk;
    logic            rst_n;
    logic            in_valid;
    logic            in_ready;
    fp32_pkg::fp32_t lhs;
    fp32_pkg::fp32_t rhs;
    logic            out_valid;
    logic            out_ready;
    fp32_pkg::fp32_t result;

    fp32_pkg::fp32_t exp_q [$];             // expected results in input order
    fp32_pkg::fp32_t lhs_q [$];
    fp32_pkg::fp32_t rhs_q [$];
    string           test_name;
    int              cyc = 0;
    int              errors = 0;
    int              checks = 0;
    int              tests_run = 0;
    int              err_start;
    int              test_ins;
    int              test_outs;
    int              stall_cycles;
    int              first_out_cyc;
    int              last_out_cyc;
    int              last_in_cyc;
    logic            bp_on;
    logic            gap_on;
    int unsigned     seed_val;

    fmul_clk_gen #(.period_ns(40), .reset_cycles(5)) u_clk_gen (.clk(clk), .rst_n(rst_n));

    fmul_pipe #(.depth(depth)) u_fmul_pipe (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .lhs       (lhs),
        .rhs       (rhs),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .result    (result)
    );

    bind fmul_pipe fmul_assert u_assert (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .result    (result)
    );

    // exact product of two finite operands worth sig * 2^(e - 150) each
    function automatic fp32_pkg::fp32_t ref_mul(input fp32_pkg::fp32_t a, input fp32_pkg::fp32_t b);
        logic        s;
        logic [63:0] pw;
        logic [63:0] q;
        logic        guard;
        logic        sticky;
        int          e;
        int          msb;
        int          be;
        int          sh;
        s = a[31] ^ b[31];
        if (a[30:23] == 8'hff && a[22:0] != 0) return {a[31:23], 1'b1, a[21:0]};
        if (b[30:23] == 8'hff && b[22:0] != 0) return {b[31:23], 1'b1, b[21:0]};
        if ((a[30:0] == 0 && b[30:0] == 31'h7f80_0000)
            || (a[30:0] == 31'h7f80_0000 && b[30:0] == 0)) return `FMUL_QNAN;
        if (a[30:0] == 31'h7f80_0000 || b[30:0] == 31'h7f80_0000) return {s, 31'h7f80_0000};
        if (a[30:0] == 0 || b[30:0] == 0) return {s, 31'h0};
        e = ((a[30:23] == 0) ? 1 : int'(a[30:23])) + ((b[30:23] == 0) ? 1 : int'(b[30:23])) - 127;
        pw = {40'h0, a[30:23] != 0, a[22:0]} * {40'h0, b[30:23] != 0, b[22:0]};
        msb = 0;
        for (int i = 0; i < 48; i++) begin
            if (pw[i]) msb = i;
        end
        be = e + msb - 46;                  // biased exponent once normalized
        sh = (be >= 1) ? msb - 23 : 24 - e; // subnormals count in units of 2^-149
        if (sh <= 0) begin
            q = pw << -sh;
            guard = 1'b0;
            sticky = 1'b0;
        end else if (sh > 60) begin
            q = '0;
            guard = 1'b0;
            sticky = 1'b1;
        end else begin
            q = pw >> sh;
            guard = pw[sh-1];
            sticky = (pw & ((64'h1 << (sh - 1)) - 1)) != 0;
        end
        q = q + 64'(guard & (sticky | q[0]));       // nearest even
        if (be < 1) return {s, q[30:0]};             // a carry lands in exponent 1
        if (q[24]) begin
            q = q >> 1;
            be++;
        end
        if (be >= 255) return {s, 31'h7f80_0000};
        return {s, 8'(be), q[22:0]};
    endfunction

    function automatic fp32_pkg::fp32_t rand_operand();
        int unsigned pick;
        logic [7:0]  e;
        pick = $urandom % 16;
        case (pick)
            0, 1:       e = 8'h00;
            2:          e = 8'hff;
            3, 4, 5, 6: e = 8'($urandom);
            default:    e = 8'(96 + ($urandom % 64));  // near one
        endcase
        return {1'($urandom), e, 23'($urandom)};
    endfunction

    task automatic check_output(input fp32_pkg::fp32_t got);
        fp32_pkg::fp32_t want;
        fp32_pkg::fp32_t a;
        fp32_pkg::fp32_t b;
        if (test_outs == 0) first_out_cyc = cyc;
        last_out_cyc = cyc;
        test_outs++;
        checks++;
        assert (exp_q.size() != 0) else begin
            $display("%s: output transfer with no input outstanding (%h)", test_name, got);
            errors++;
        end
        if (exp_q.size() != 0) begin
            want = exp_q.pop_front();
            a = lhs_q.pop_front();
            b = rhs_q.pop_front();
            assert (got === want) else begin
                $display("error %s: lhs %h rhs %h expected %h actual %h", test_name, a, b,
                         want, got);
                errors++;
            end
        end
    endtask

    always @(posedge clk) cyc <= cyc + 1;

    // scoreboard samples both sides mid-cycle where the handshake is settled
    always @(negedge clk) begin
        if (rst_n) begin
            if (in_valid && in_ready) begin
                exp_q.push_back(ref_mul(lhs, rhs));
                lhs_q.push_back(lhs);
                rhs_q.push_back(rhs);
                test_ins++;
                last_in_cyc = cyc;
            end
            if (in_valid && !in_ready) stall_cycles++;
            if (out_valid && out_ready) check_output(result);
        end
    end

    initial begin
        out_ready = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            out_ready = bp_on ? ($urandom % 3 != 0) : 1'b1;
        end
    end

    task automatic send_pair(input fp32_pkg::fp32_t a, input fp32_pkg::fp32_t b);
        if (gap_on && ($urandom % 4 == 0)) begin
            in_valid = 1'b0;
            @(posedge clk);
            #1;
        end
        in_valid = 1'b1;
        lhs = a;
        rhs = b;
        @(negedge clk);
        while (!in_ready) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    // the reference is held to a hand-worked value before the DUT sees the pair
    task automatic check_known(input fp32_pkg::fp32_t a, input fp32_pkg::fp32_t b,
                               input fp32_pkg::fp32_t want);
        checks++;
        assert (ref_mul(a, b) === want) else begin
            $display("error %s reference: lhs %h rhs %h expected %h actual %h", test_name,
                     a, b, want, ref_mul(a, b));
            errors++;
        end
        send_pair(a, b);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_ins = 0;
        test_outs = 0;
        stall_cycles = 0;
        err_start = errors;
        tests_run++;
    endtask

    task automatic drain_pipe();
        in_valid = 1'b0;
        while (exp_q.size() != 0) @(posedge clk);
        repeat (depth + 2) @(posedge clk); // catch a duplicated result
        #1;
        checks++;
        assert (test_outs == test_ins) else begin
            $display("%s: %0d results for %0d inputs", test_name, test_outs, test_ins);
            errors++;
        end
    endtask

    task automatic end_test();
        $display("%s done: %0d in, %0d out, %0d errors", test_name, test_ins, test_outs,
                 errors - err_start);
    endtask

    initial begin
        seed_val = $urandom(32'had63_f461);
        in_valid = 1'b0;
        lhs = '0;
        rhs = '0;
        bp_on = 1'b0;
        gap_on = 1'b0;
        wait (rst_n === 1'b1);
        @(posedge clk);
        #1;

        start_test("directed_normal");
        check_known(32'h3fc0_0000, 32'h4000_0000, 32'h4040_0000);   // 1.5 x 2.0
        check_known(32'hc040_0000, 32'h3f00_0000, 32'hbfc0_0000);   // -3.0 x 0.5
        check_known(32'h3f80_0001, 32'h3fc0_0000, 32'h3fc0_0002);   // tie goes to even
        drain_pipe();
        end_test();

        start_test("special_cases");
        check_known(32'h7f80_0001, 32'h3f80_0000, 32'h7fc0_0001);   // quieted, payload kept
        check_known(32'hffa0_0005, 32'h7fc0_0000, 32'hffe0_0005);   // lhs NaN wins
        check_known(32'h3f80_0000, 32'h7f81_2345, 32'h7fc1_2345);
        check_known(32'h0000_0000, 32'h7f80_0000, `FMUL_QNAN);
        check_known(32'hff80_0000, 32'h8000_0000, `FMUL_QNAN);
        check_known(32'hff80_0000, 32'h4000_0000, 32'hff80_0000);
        check_known(32'h7f80_0000, 32'h0000_0001, 32'h7f80_0000);
        check_known(32'h8000_0000, 32'h3f80_0000, 32'h8000_0000);
        check_known(32'h0000_0000, 32'hc000_0000, 32'h8000_0000);
        drain_pipe();
        end_test();

        start_test("subnormal_range");
        check_known(32'h0d80_0000, 32'h3080_0000, 32'h0008_0000);   // 2^-100 x 2^-30
        check_known(32'h0000_0001, 32'h4e80_0000, 32'h0400_0000);   // escapes to normal
        check_known(32'h0040_0000, 32'h3f00_0000, 32'h0020_0000);   // stays subnormal
        check_known(32'h007f_ffff, 32'h3f80_0001, 32'h0080_0000);   // rounds up to normal
        check_known(32'h0000_0001, 32'h3f00_0000, 32'h0000_0000);   // tie to even zero
        check_known(32'h0000_0003, 32'h3f00_0000, 32'h0000_0002);   // tie to even two
        check_known(32'h7180_0000, 32'h7180_0000, 32'h7f80_0000);   // overflow
        check_known(32'hf180_0000, 32'h7180_0000, 32'hff80_0000);
        check_known(32'h0d80_0000, 32'h8d80_0000, 32'h8000_0000);   // deep underflow
        drain_pipe();
        end_test();

        start_test("random_stream");
        for (int i = 0; i < n_random; i++) send_pair(rand_operand(), rand_operand());
        drain_pipe();
        checks++;
        assert (last_out_cyc - first_out_cyc == n_random - 1) else begin
            $display("%s: out_valid had gaps, %0d cycles for %0d results", test_name,
                     last_out_cyc - first_out_cyc + 1, n_random);
            errors++;
        end
        end_test();

        start_test("backpressure");
        bp_on = 1'b1;
        gap_on = 1'b1;
        for (int i = 0; i < n_stall; i++) send_pair(rand_operand(), rand_operand());
        drain_pipe();
        bp_on = 1'b0;
        gap_on = 1'b0;
        checks++;
        assert (stall_cycles != 0) else begin
            $display("%s: in_ready never dropped while the output was held back", test_name);
            errors++;
        end
        end_test();

        start_test("latency");
        send_pair(32'h4040_0000, 32'h4040_0000);
        drain_pipe();
        checks++;
        assert (last_out_cyc - last_in_cyc == depth) else begin
            $display("error %s: expected %0d actual %0d", test_name, depth,
                     last_out_cyc - last_in_cyc);
            errors++;
        end
        end_test();

        errors = errors + u_fmul_pipe.u_assert.fail_count;
        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // every operation may wait under back-pressure
    initial begin
        repeat (total_ops * depth * 4 + 200) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", total_ops * depth * 4 + 200);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+include
logic/fp32_pkg.sv
logic/fmul_pkg.sv
logic/fmul_classify.sv
logic/fmul_mant_mult.sv
logic/fmul_round_pack.sv
logic/fmul_pipe.sv
tests/fmul_clk_gen.sv
tests/fmul_assert.sv
tests/fmul_tb.sv

//--- run.sh
#!/bin/sh
# Build the floating-point multiplier testbench with Verilator and run it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f project.f --top-module fmul_tb -o fmul_sim

sim_out=$(./obj_dir/fmul_sim)
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx 'Result: PASSED'; then
    exit 0
fi
exit 1
